/* verilog/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry
    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 5;                              // byte offset in a line
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;    // 23
    localparam int SETS     = 1 << INDEX_W;
    localparam int WAYS     = 4;
    localparam int WORDS    = 1 << (OFFSET_W - 2);            // words per line

    // burst encoding, 8 beats of 4 bytes
    localparam logic [3:0] BURST_LEN = 4'd7;
    localparam logic [2:0] WORD_SIZE = 3'b010;

    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [OFFSET_W-3:0]   word_t;
    typedef logic [1:0]            way_t;
    typedef logic [3:0]            strb_t;

    // strb of zero means load
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        strb_t             strb;
        logic [31:0]       data;
    } cpu_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [3:0]        len;
        logic [2:0]        size;
    } mem_ar_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [3:0]        len;
        logic [2:0]        size;
    } mem_aw_t;

    typedef struct packed {
        logic [31:0] data;
        strb_t       strb;
        logic        last;
    } mem_w_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL
    } cache_state_e;

endpackage

/* verilog/tag_store.sv */
module tag_store import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  index_t index,
    input  tag_t   tag,

    input  logic   store_hit,
    input  logic   install,

    input  way_t   fill_way,
    output way_t   hit_way,
    output logic   hit,

    input  way_t   victim_way,
    output logic   victim_dirty,
    output tag_t   victim_tag
);

    tag_t             tags  [WAYS][SETS];
    logic [SETS-1:0]  valid [WAYS];
    logic [SETS-1:0]  dirty [WAYS];
    logic [WAYS-1:0]  match;

    // all ways compared at once
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            match[i] = valid[i][index] & (tags[i][index] == tag);
        end
    end

    assign hit = |match;

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (match[i]) begin
                hit_way = way_t'(i);
            end
        end
    end

    assign victim_dirty = valid[victim_way][index] & dirty[victim_way][index];
    assign victim_tag   = tags[victim_way][index];  // writeback line address

    always_ff @(posedge clk) begin
        if (install) begin
            tags[fill_way][index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < WAYS; i++) begin
                valid[i] <= '0;
                dirty[i] <= '0;
            end
        end else if (install) begin
            valid[fill_way][index] <= 1'b1;
            dirty[fill_way][index] <= 1'b0;  // fresh line is clean
        end else if (store_hit) begin
            dirty[hit_way][index] <= 1'b1;
        end
    end

endmodule

/* verilog/plru.sv */
module plru import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  index_t index,
    input  logic   touch,
    input  way_t   touch_way,
    output way_t   victim_way
);

    // bit 0 is the root, 1 picks in {0,1}, 2 picks in {2,3}
    logic [2:0] tree [SETS];
    logic [2:0] cur;

    assign cur = tree[index];

    assign victim_way = {cur[0], cur[0] ? cur[2] : cur[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            // point the path away from the touched way
            tree[index][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree[index][2] <= ~touch_way[0];
            end else begin
                tree[index][1] <= ~touch_way[0];
            end
        end
    end

endmodule

/* verilog/data_store.sv */
module data_store import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  index_t      index,
    input  word_t       word,

    input  logic        store_hit,
    input  way_t        hit_way,
    input  strb_t       strb,
    input  logic [31:0] wdata,

    input  logic        refill_beat,
    input  word_t       refill_word,
    input  logic [31:0] refill_data,
    input  way_t        fill_way,

    input  word_t       wb_word_sel,

    output logic [31:0] rdata,
    output logic [31:0] wb_data
);

    logic [31:0] mem [WAYS][SETS][WORDS];
    logic [31:0] merged;
    logic [31:0] old_word;

    assign old_word = mem[hit_way][index][word];

    // byte merge under the store strobe
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = strb[b] ? wdata[8*b +: 8] : old_word[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin  // no writes while in reset
            if (refill_beat) begin
                mem[fill_way][index][refill_word] <= refill_data;
            end else if (store_hit) begin
                mem[hit_way][index][word] <= merged;
            end
        end
    end

    assign rdata   = old_word;
    assign wb_data = mem[fill_way][index][wb_word_sel];  // victim word for current beat

endmodule

/* verilog/axi_burst.sv */
module axi_burst import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start_wb,
    input  logic        start_refill,

    input  index_t      index,
    input  tag_t        tag,
    input  tag_t        victim_tag,
    input  logic [31:0] wb_data,

    output mem_ar_t     ar,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] r_data,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready,

    output mem_aw_t     aw,
    output logic        awvalid,
    input  logic        awready,
    output mem_w_t      w,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready,

    output logic        refill_beat,
    output word_t       refill_word,
    output word_t       wb_word_sel,
    output logic        refill_done,
    output logic        wb_done
);

    logic              read_req, raddr_rcv;
    logic              write_req, waddr_rcv, wdata_rcv;
    logic [ADDR_W-1:0] rd_addr, wr_addr;
    word_t             rcnt, wcnt;
    logic              w_beat;

    // line-aligned addresses, taken at the start pulse
    always_ff @(posedge clk) begin
        if (start_refill) begin
            rd_addr <= {tag, index, {OFFSET_W{1'b0}}};
        end
        if (start_wb) begin
            wr_addr <= {victim_tag, index, {OFFSET_W{1'b0}}};
        end
    end

    assign refill_beat = raddr_rcv & rvalid;  // rready is raddr_rcv
    assign refill_done = refill_beat & rlast;
    assign w_beat      = wvalid & wready;
    assign wb_done     = wdata_rcv & bvalid & bready;

    always_ff @(posedge clk) begin
        if (rst) begin
            read_req  <= 1'b0;
            raddr_rcv <= 1'b0;
            rcnt      <= '0;
        end else begin
            if (start_refill) read_req <= 1'b1;
            else if (refill_done) read_req <= 1'b0;
            if (arvalid && arready) raddr_rcv <= 1'b1;
            else if (refill_done) raddr_rcv <= 1'b0;
            if (refill_done) rcnt <= '0;
            else if (refill_beat) rcnt <= rcnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            write_req <= 1'b0;
            waddr_rcv <= 1'b0;
            wdata_rcv <= 1'b0;
            wcnt      <= '0;
        end else begin
            if (start_wb) write_req <= 1'b1;
            else if (wb_done) write_req <= 1'b0;
            if (awvalid && awready) waddr_rcv <= 1'b1;
            else if (wb_done) waddr_rcv <= 1'b0;
            if (w_beat && w.last) wdata_rcv <= 1'b1;  // all beats out
            else if (wb_done) wdata_rcv <= 1'b0;
            if (wb_done) wcnt <= '0;
            else if (w_beat) wcnt <= wcnt + 1'b1;
        end
    end

    assign ar      = '{addr: rd_addr, len: BURST_LEN, size: WORD_SIZE};
    assign arvalid = read_req & ~raddr_rcv;
    assign rready  = raddr_rcv;

    assign aw      = '{addr: wr_addr, len: BURST_LEN, size: WORD_SIZE};
    assign awvalid = write_req & ~waddr_rcv;
    assign w       = '{data: wb_data, strb: 4'hf, last: wcnt == word_t'(BURST_LEN)};
    assign wvalid  = waddr_rcv & ~wdata_rcv;
    assign bready  = waddr_rcv;

    assign refill_word = rcnt;
    assign wb_word_sel = wcnt;

endmodule

/* verilog/dcache_ctrl.sv */
module dcache_ctrl import dcache_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     req_en,
    input  cpu_req_t req,

    input  logic     hit,
    input  way_t     hit_way,
    input  way_t     victim_way,
    input  logic     victim_dirty,

    input  logic     refill_done,
    input  logic     wb_done,

    output logic     stall,
    output way_t     fill_way,
    output logic     start_wb,
    output logic     start_refill,

    output logic     store_hit,
    output logic     install,
    output logic     touch,
    output way_t     touch_way
);

    cache_state_e state, state_next;
    logic         idle_hit, idle_miss;

    assign idle_hit  = (state == IDLE) & req_en & hit;
    assign idle_miss = (state == IDLE) & req_en & ~hit;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (idle_miss) begin
                    state_next = victim_dirty ? WRITEBACK : REFILL;
                end
            end
            WRITEBACK: begin
                if (wb_done) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (refill_done) begin
                    state_next = IDLE;  // replay hits next cycle
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // victim stays put for the whole miss
    always_ff @(posedge clk) begin
        if (idle_miss) begin
            fill_way <= victim_way;
        end
    end

    assign start_wb     = idle_miss & victim_dirty;
    assign start_refill = (idle_miss & ~victim_dirty) | ((state == WRITEBACK) & wb_done);

    assign stall = (state != IDLE) | idle_miss;

    assign store_hit = idle_hit & (|req.strb);
    assign install   = (state == REFILL) & refill_done;
    assign touch     = idle_hit | install;
    assign touch_way = idle_hit ? hit_way : fill_way;  // refilled way counts as access

endmodule

/* verilog/dcache_top.sv */
module dcache_top import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        req_en,
    input  cpu_req_t    req,
    output logic [31:0] rdata,
    output logic        stall,

    output mem_ar_t     ar,
    output logic        arvalid,
    input  logic        arready,

    input  logic [31:0] r_data,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready,

    output mem_aw_t     aw,
    output logic        awvalid,
    input  logic        awready,

    output mem_w_t      w,
    output logic        wvalid,
    input  logic        wready,

    input  logic        bvalid,
    output logic        bready
);

    tag_t   tag;
    index_t index;
    word_t  word;

    logic        hit, victim_dirty;
    way_t        hit_way, victim_way, fill_way, touch_way;
    tag_t        victim_tag;
    logic        store_hit, install, touch;
    logic        start_wb, start_refill;
    logic        refill_beat, refill_done, wb_done;
    word_t       refill_word, wb_word_sel;
    logic [31:0] wb_data;

    // address fields
    assign tag   = req.addr[ADDR_W-1 -: TAG_W];
    assign index = req.addr[OFFSET_W +: INDEX_W];
    assign word  = req.addr[OFFSET_W-1:2];

    dcache_ctrl u_ctrl (
        .clk, .rst, .req_en, .req,
        .hit, .hit_way, .victim_way, .victim_dirty,
        .refill_done, .wb_done,
        .stall, .fill_way, .start_wb, .start_refill,
        .store_hit, .install, .touch, .touch_way
    );

    tag_store u_tags (
        .clk, .rst, .index, .tag,
        .store_hit, .install,
        .fill_way, .hit_way, .hit,
        .victim_way, .victim_dirty, .victim_tag
    );

    plru u_plru (
        .clk, .rst, .index, .touch, .touch_way, .victim_way
    );

    data_store u_data (
        .clk, .rst, .index, .word,
        .store_hit, .hit_way, .strb(req.strb), .wdata(req.data),
        .refill_beat, .refill_word, .refill_data(r_data), .fill_way,
        .wb_word_sel,
        .rdata, .wb_data
    );

    axi_burst u_axi (
        .clk, .rst, .start_wb, .start_refill,
        .index, .tag, .victim_tag, .wb_data,
        .ar, .arvalid, .arready,
        .r_data, .rlast, .rvalid, .rready,
        .aw, .awvalid, .awready,
        .w, .wvalid, .wready,
        .bvalid, .bready,
        .refill_beat, .refill_word, .wb_word_sel,
        .refill_done, .wb_done
    );

endmodule

/* tests/dcache_asserts.sv */
module dcache_asserts import dcache_pkg::*; (
    input logic    clk,
    input logic    rst,
    input mem_ar_t ar,
    input logic    arvalid,
    input logic    arready,
    input mem_aw_t aw,
    input logic    awvalid,
    input logic    awready,
    input mem_w_t  w,
    input logic    wvalid,
    input logic    wready
);

    int unsigned fail_count = 0;
    logic [3:0]  beat;

    // write beats seen in the current burst
    always_ff @(posedge clk) begin
        if (rst || (wvalid && wready && w.last)) begin
            beat <= '0;
        end else if (wvalid && wready) begin
            beat <= beat + 1'b1;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            $error("read address changed or dropped before arready");
            fail_count++;
        end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin
            $error("write address changed or dropped before awready");
            fail_count++;
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(w))
        else begin
            $error("write beat changed or dropped before wready");
            fail_count++;
        end

    last_beat: assert property (@(posedge clk) disable iff (rst)
        wvalid |-> (w.last == (beat == 4'd7)))  // last only on beat 8
        else begin
            $error("w.last does not mark the eighth beat");
            fail_count++;
        end

endmodule

bind axi_burst dcache_asserts u_asserts (.*);

/* tests/dcache_checker.sv */
module dcache_checker import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        req_en,
    input  cpu_req_t    req,
    input  logic        stall,
    input  logic [31:0] rdata,
    input  logic [31:0] exp_data,
    input  mem_ar_t     ar,
    input  logic        arvalid,
    input  logic        arready,
    input  mem_aw_t     aw,
    input  logic        awvalid,
    input  logic        awready,
    input  mem_w_t      w,
    input  logic        wvalid,
    input  logic        wready,
    output int          value_errs,
    output int          proto_errs
);

    logic [31:0] shadow [logic [31:0]];  // stored words by byte address
    tag_t        line_tag   [SETS][WAYS];
    logic        line_val   [SETS][WAYS];
    logic        line_dirty [SETS][WAYS];
    logic        root_bit [SETS];  // 1 points at ways 2,3
    logic        pair_lo  [SETS];  // 1 points at way 1
    logic        pair_hi  [SETS];  // 1 points at way 3
    logic        had_aw, in_reset;
    logic [31:0] ar_addr, aw_addr;
    int          n_ar, w_beats;

    function automatic logic [31:0] expected_word(logic [31:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 32'h5a5a0000;  // memory pattern
    endfunction

    function automatic way_t pick_victim(index_t s);
        if (root_bit[s]) begin
            return pair_hi[s] ? 2'd3 : 2'd2;
        end
        return pair_lo[s] ? 2'd1 : 2'd0;
    endfunction

    // tree bits turn away from the way just used
    task automatic mark_used(index_t s, way_t v);
        root_bit[s] = (v < 2);
        if (v < 2) begin
            pair_lo[s] = (v == 0);
        end else begin
            pair_hi[s] = (v == 2);
        end
    endtask

    task automatic value_error(string what, logic [31:0] got, logic [31:0] want);
        value_errs++;
        $display("FAILED at %0t: %s got %h expected %h", $time, what, got, want);
    endtask

    task automatic protocol_error(string what);
        proto_errs++;
        $display("protocol error at %0t: %s", $time, what);
    endtask

    always @(posedge clk) begin
        index_t      s;
        tag_t        t;
        way_t        v;
        logic        hit;
        logic [31:0] a, old, merged;
        if (rst) begin
            for (int i = 0; i < SETS; i++) begin
                root_bit[i] = 1'b0;
                pair_lo[i]  = 1'b0;
                pair_hi[i]  = 1'b0;
                for (int j = 0; j < WAYS; j++) begin
                    line_val[i][j]   = 1'b0;
                    line_dirty[i][j] = 1'b0;
                end
            end
            shadow.delete();
            value_errs = 0;
            proto_errs = 0;
            n_ar       = 0;
            had_aw     = 1'b0;
            in_reset   = 1'b1;
        end else begin
            if (in_reset && (stall || arvalid || awvalid)) begin
                protocol_error("stall, arvalid or awvalid high right after reset");
            end
            in_reset = 1'b0;
            if (arvalid && arready) begin
                n_ar++;
                ar_addr = ar.addr;
                if (ar.len != 4'd7) protocol_error("read burst length is not 7");
                if (ar.size != 3'b010) protocol_error("read burst size is not one word");
            end
            if (awvalid && awready) begin
                had_aw  = 1'b1;
                aw_addr = aw.addr;
                w_beats = 0;
                if (aw.len != 4'd7) protocol_error("write burst length is not 7");
                if (aw.size != 3'b010) protocol_error("write burst size is not one word");
            end
            if (wvalid && wready) begin
                a = aw_addr + 4 * w_beats;
                if (w.data !== expected_word(a)) begin
                    value_error("writeback data", w.data, expected_word(a));
                end
                if (w.strb != 4'hf) protocol_error("writeback beat without full strobe");
                w_beats++;
            end
            if (req_en && !stall) begin  // request completes here
                a   = {req.addr[ADDR_W-1:2], 2'b00};
                s   = req.addr[OFFSET_W +: INDEX_W];
                t   = req.addr[ADDR_W-1 -: TAG_W];
                hit = 1'b0;
                v   = '0;
                for (int i = 0; i < WAYS; i++) begin
                    if (line_val[s][i] && line_tag[s][i] == t) begin
                        hit = 1'b1;
                        v   = way_t'(i);
                    end
                end
                if (hit && (n_ar != 0 || had_aw)) begin
                    protocol_error("request to a cached line started a burst");
                end
                if (!hit) begin
                    v = pick_victim(s);
                    if (n_ar != 1 || ar_addr != {req.addr[ADDR_W-1:OFFSET_W], 5'b0}) begin
                        protocol_error("miss did not issue one read burst for its line");
                    end
                    if (had_aw != (line_val[s][v] && line_dirty[s][v])) begin
                        protocol_error("writeback does not match the dirty state of the victim");
                    end else if (had_aw && aw_addr != {line_tag[s][v], s, 5'b0}) begin
                        protocol_error("writeback sent to the wrong line address");
                    end else if (had_aw && w_beats != 8) begin
                        protocol_error("writeback did not carry 8 beats");
                    end
                    line_tag[s][v]   = t;
                    line_val[s][v]   = 1'b1;
                    line_dirty[s][v] = 1'b0;
                end
                mark_used(s, v);
                old = expected_word(a);
                if (req.strb == '0) begin
                    if (rdata !== old) value_error("load vs shadow memory", rdata, old);
                    if (rdata !== exp_data) value_error("load vs input file", rdata, exp_data);
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        merged[8*b +: 8] = req.strb[b] ? req.data[8*b +: 8] : old[8*b +: 8];
                    end
                    shadow[a]        = merged;
                    line_dirty[s][v] = 1'b1;
                end
                n_ar   = 0;
                had_aw = 1'b0;
            end
        end
    end

endmodule

/* tests/tb_dcache.sv */
module tb_dcache import dcache_pkg::*; ();

    localparam int MAX_REQ = 64;

    logic        clk, rst;
    logic        req_en;
    cpu_req_t    req;
    logic [31:0] rdata;
    logic        stall;
    mem_ar_t     ar;
    logic        arvalid, arready;
    logic [31:0] r_data;
    logic        rlast, rvalid, rready;
    mem_aw_t     aw;
    logic        awvalid, awready;
    mem_w_t      w;
    logic        wvalid, wready;
    logic        bvalid, bready;

    logic [31:0] stim [4*MAX_REQ];        // op, addr, strb, data per request
    logic [31:0] exp_data;
    logic [31:0] backing [logic [31:0]];  // written-back words
    logic [31:0] rd_addr, wr_addr;
    logic [3:0]  rd_beat, wr_beat;
    logic        rd_active, b_pending;
    int          n_req, cycles, limit, setup_errs;
    int          value_errs, proto_errs;

    dcache_top u_dut (.*);

    dcache_checker u_check (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] mem_word(logic [31:0] a);
        if (backing.exists(a)) begin
            return backing[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    task automatic print_counts();
        $display("errors: %0d value, %0d protocol, %0d assertion, %0d setup",
                 value_errs, proto_errs, u_dut.u_axi.u_asserts.fail_count, setup_errs);
    endtask

    task automatic wait_done();
        do begin
            @(posedge clk);
        end while (stall);
    endtask

    // memory slave, handshakes taken at the rising edge
    always @(posedge clk) begin
        if (rst) begin
            rd_active <= 1'b0;
            b_pending <= 1'b0;
            rd_beat   <= '0;
            wr_beat   <= '0;
        end else begin
            if (arvalid && arready) begin
                rd_addr   <= ar.addr;
                rd_active <= 1'b1;
                rd_beat   <= '0;
            end
            if (rvalid && rready) begin
                rd_beat <= rd_beat + 1'b1;
                if (rlast) rd_active <= 1'b0;
            end
            if (awvalid && awready) begin
                wr_addr <= aw.addr;
                wr_beat <= '0;
            end
            if (wvalid && wready) begin
                backing[wr_addr + 4 * wr_beat] = w.data;
                wr_beat <= wr_beat + 1'b1;
                if (w.last) b_pending <= 1'b1;
            end
            if (bvalid && bready) b_pending <= 1'b0;
        end
    end

    // slave readies and response beats on the falling edge
    initial begin
        void'($urandom(32'h3e));
        forever begin
            @(negedge clk);
            arready <= ($urandom % 4) != 0;  // ready three times in four
            awready <= ($urandom % 4) != 0;
            wready  <= ($urandom % 4) != 0;
            rvalid  <= rd_active;
            rlast   <= rd_active && rd_beat == 4'd7;
            r_data  <= rd_active ? mem_word(rd_addr + 4 * rd_beat) : '0;
            bvalid  <= b_pending;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, a request never completed", cycles);
            print_counts();
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        req_en = 1'b0;
        req = '0;
        exp_data = '0;
        arready = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        rvalid = 1'b0;
        rlast = 1'b0;
        r_data = '0;
        bvalid = 1'b0;
        cycles = 0;
        setup_errs = 0;
        $readmemh("tests/dcache_input.txt", stim);
        n_req = 0;
        while (n_req < MAX_REQ && (stim[4*n_req] === 32'd1 || stim[4*n_req] === 32'd2)) begin
            n_req++;
        end
        limit = n_req * 60 + 100;
        if (n_req == 0) begin
            $display("no requests found in tests/dcache_input.txt");
            setup_errs++;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        @(negedge clk);  // one idle cycle for the reset check
        for (int i = 0; i < n_req; i++) begin
            req_en   <= 1'b1;
            req.addr <= stim[4*i+1];
            req.strb <= strb_t'(stim[4*i+2]);
            req.data <= (stim[4*i] == 32'd2) ? stim[4*i+3] : '0;
            exp_data <= stim[4*i+3];
            wait_done();
            @(negedge clk);
        end
        req_en <= 1'b0;
        repeat (4) @(negedge clk);
        print_counts();
        if (value_errs + proto_errs + setup_errs + u_dut.u_axi.u_asserts.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* tests/dcache_input.txt */
// op addr strb data, one request per line
// op 1 is a load (data column holds the expected read word), op 2 is a store
1 00000004 0 5a5a0004
1 00000004 0 5a5a0004
1 0000001c 0 5a5a001c
2 00000008 3 1122aabb
1 00000008 0 5a5aaabb
2 00000008 c ccdd0000
1 00000008 0 ccddaabb
1 00000200 0 5a5a0200
2 00000400 f deadbeef
1 00000600 0 5a5a0600
1 00000800 0 5a5a0800
1 00000008 0 ccddaabb
1 00000404 0 5a5a0404
1 00000400 0 deadbeef
1 00000024 0 5a5a0024
2 00000200 1 00000077
1 00000200 0 5a5a0277
1 00000a00 0 5a5a0a00
1 00000600 0 5a5a0600
1 00000c00 0 5a5a0c00
1 00000400 0 deadbeef
1 00000200 0 5a5a0277

/* src.f */
verilog/dcache_pkg.sv
verilog/tag_store.sv
verilog/plru.sv
verilog/data_store.sv
verilog/axi_burst.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tests/dcache_asserts.sv
tests/dcache_checker.sv
tests/tb_dcache.sv

/* Makefile */
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module tb_dcache

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_dcache -o sim_dcache
	-./obj_dir/sim_dcache +verilator+error+limit+1000 > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
